//--- logic/isa_pkg.sv
// Instruction set definitions for the pipeline control unit
// Word and register specifier types, field positions, match/mask pairs
package isa_pkg;

  // Fixed by the ISA
  localparam int inst_w     = 32;
  localparam int num_regs   = 32;
  localparam int reg_addr_w = $clog2(num_regs);

  typedef logic [inst_w-1:0]     inst_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // Lsb position of each register specifier field
  localparam int rd_lsb  = 7;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;

  // x0 is hardwired, so it never carries a dependency
  localparam reg_addr_t zero_reg = '0;

  // ------------------------------------------------------------------------
  // Match and mask pairs, an instruction hits when (word & mask) == match
  // ------------------------------------------------------------------------

  // Nop is addi x0, x0, 0 and must be tested before addi
  localparam inst_t inst_nop       = 32'h0000_0013;
  localparam inst_t inst_nop_mask  = 32'hffff_ffff;

  // Register-register, funct7 + funct3 + opcode
  localparam inst_t inst_add       = 32'h0000_0033;
  localparam inst_t inst_add_mask  = 32'hfe00_707f;
  localparam inst_t inst_sub       = 32'h4000_0033;
  localparam inst_t inst_sub_mask  = 32'hfe00_707f;
  localparam inst_t inst_xor       = 32'h0000_4033;
  localparam inst_t inst_xor_mask  = 32'hfe00_707f;
  localparam inst_t inst_or        = 32'h0000_6033;
  localparam inst_t inst_or_mask   = 32'hfe00_707f;
  localparam inst_t inst_and       = 32'h0000_7033;
  localparam inst_t inst_and_mask  = 32'hfe00_707f;

  // Register-immediate, funct3 + opcode
  localparam inst_t inst_addi      = 32'h0000_0013;
  localparam inst_t inst_addi_mask = 32'h0000_707f;
  localparam inst_t inst_xori      = 32'h0000_4013;
  localparam inst_t inst_xori_mask = 32'h0000_707f;
  localparam inst_t inst_ori       = 32'h0000_6013;
  localparam inst_t inst_ori_mask  = 32'h0000_707f;
  localparam inst_t inst_andi      = 32'h0000_7013;
  localparam inst_t inst_andi_mask = 32'h0000_707f;

  // Load word and branch not equal
  localparam inst_t inst_lw        = 32'h0000_2003;
  localparam inst_t inst_lw_mask   = 32'h0000_707f;
  localparam inst_t inst_bne       = 32'h0000_1063;
  localparam inst_t inst_bne_mask  = 32'h0000_707f;

endpackage

//--- logic/ctrl_pkg.sv
// Control code types and encodings shared by decode and the back stages
// ALU function, immediate type, operand/writeback select, memory, branch, PC
package ctrl_pkg;

  typedef logic [3:0] alu_fn_t;
  typedef logic [2:0] imm_type_t;
  typedef logic [1:0] op2_sel_t;
  typedef logic [1:0] mem_type_t;
  typedef logic       wb_sel_t;
  typedef logic [2:0] br_type_t;
  typedef logic [1:0] pc_sel_t;

  // ALU function, encoding matches the datapath ALU
  localparam alu_fn_t alu_add = 4'd0;
  localparam alu_fn_t alu_sub = 4'd1;
  localparam alu_fn_t alu_xor = 4'd2;
  localparam alu_fn_t alu_and = 4'd3;
  localparam alu_fn_t alu_or  = 4'd4;

  // Immediate generator format
  localparam imm_type_t imm_i = 3'd0;
  localparam imm_type_t imm_s = 3'd1;
  localparam imm_type_t imm_b = 3'd2;
  localparam imm_type_t imm_u = 3'd3;
  localparam imm_type_t imm_j = 3'd4;

  // Second ALU operand, register file or immediate
  localparam op2_sel_t op2_rf  = 2'd0;
  localparam op2_sel_t op2_imm = 2'd1;

  // Data memory request kind
  localparam mem_type_t mem_none = 2'd0;
  localparam mem_type_t mem_load = 2'd1;

  // Writeback source
  localparam wb_sel_t wb_alu = 1'b0;
  localparam wb_sel_t wb_mem = 1'b1;

  localparam br_type_t br_none = 3'd0;
  localparam br_type_t br_bne  = 3'd1;

  // Next fetch address
  localparam pc_sel_t pc_plus4  = 2'd0;
  localparam pc_sel_t pc_branch = 2'd1;

endpackage

//--- logic/decode_if.sv
// Decoded control bundle of the instruction sitting in decode
`timescale 1ns/1ns

interface decode_if import isa_pkg::*, ctrl_pkg::*;;

  // Source specifiers and whether each one is really read
  reg_addr_t rs1;
  reg_addr_t rs2;
  logic      rs1_en;
  logic      rs2_en;

  // Destination
  reg_addr_t rf_waddr;
  logic      rf_wen;

  // Controls carried down the back stages
  alu_fn_t   alu_fn;
  mem_type_t mem_type;
  wb_sel_t   wb_sel;
  br_type_t  br_type;

  modport decoder (
    output rs1, rs2, rs1_en, rs2_en, rf_waddr, rf_wen,
    output alu_fn, mem_type, wb_sel, br_type
  );

  modport reader (
    input rs1, rs2, rs1_en, rs2_en, rf_waddr, rf_wen,
    input alu_fn, mem_type, wb_sel, br_type
  );

endinterface

//--- logic/stall_if.sv
// Stall and squash signals between the back stages and front-stage control
`timescale 1ns/1ns

interface stall_if;

  // Stall origins in execute and memory
  logic       ostall_x;
  logic       ostall_m;

  // Taken branch in execute
  logic       osquash_x;
  logic       pc_redirect_x;

  // Raw source match per operand, bit 0 is rs1 and bit 1 is rs2
  logic [1:0] hazard_d;

  // Decode instruction leaving for execute this cycle
  logic       next_val_d;

  modport tracker (
    output ostall_x, ostall_m, osquash_x, pc_redirect_x, hazard_d,
    input  next_val_d
  );

  modport front (
    input  ostall_x, ostall_m, osquash_x, pc_redirect_x, hazard_d,
    output next_val_d
  );

endinterface

//--- logic/instr_decoder.sv
// Decode table for the decode-stage instruction
// Produces the control bundle and extracts rd, rs1 and rs2
`timescale 1ns/1ns

module instr_decoder import isa_pkg::*, ctrl_pkg::*; (
  input  inst_t     inst_d,
  output op2_sel_t  op2_sel_d,
  output imm_type_t imm_type_d,
  decode_if.decoder dec
);

  // Local copies of the table outputs
  br_type_t  br_type;
  logic      rs1_en;
  logic      rs2_en;
  alu_fn_t   alu_fn;
  mem_type_t mem_type;
  wb_sel_t   wb_sel;
  logic      rf_wen;

  // True when the word matches one table entry
  function automatic logic hit(input inst_t match, input inst_t mask);
    return (inst_d & mask) == match;
  endfunction

  // One table row
  task automatic cs(
    input br_type_t  c_br,
    input imm_type_t c_imm,
    input logic      c_rs1_en,
    input op2_sel_t  c_op2,
    input logic      c_rs2_en,
    input alu_fn_t   c_alu,
    input mem_type_t c_mem,
    input wb_sel_t   c_wb,
    input logic      c_wen
  );
    br_type    = c_br;
    imm_type_d = c_imm;
    rs1_en     = c_rs1_en;
    op2_sel_d  = c_op2;
    rs2_en     = c_rs2_en;
    alu_fn     = c_alu;
    mem_type   = c_mem;
    wb_sel     = c_wb;
    rf_wen     = c_wen;
  endtask

  // ------------------------------------------------------------------------
  // Control table
  // ------------------------------------------------------------------------
  //                br       imm    rs1   op2      rs2   alu      mem       wb      wen
  always_comb begin
    if (hit(inst_nop, inst_nop_mask))
      cs(br_none, imm_i, 1'b0, op2_rf,  1'b0, alu_add, mem_none, wb_alu, 1'b0);
    else if (hit(inst_add, inst_add_mask))
      cs(br_none, imm_i, 1'b1, op2_rf,  1'b1, alu_add, mem_none, wb_alu, 1'b1);
    else if (hit(inst_sub, inst_sub_mask))
      cs(br_none, imm_i, 1'b1, op2_rf,  1'b1, alu_sub, mem_none, wb_alu, 1'b1);
    else if (hit(inst_and, inst_and_mask))
      cs(br_none, imm_i, 1'b1, op2_rf,  1'b1, alu_and, mem_none, wb_alu, 1'b1);
    else if (hit(inst_or, inst_or_mask))
      cs(br_none, imm_i, 1'b1, op2_rf,  1'b1, alu_or,  mem_none, wb_alu, 1'b1);
    else if (hit(inst_xor, inst_xor_mask))
      cs(br_none, imm_i, 1'b1, op2_rf,  1'b1, alu_xor, mem_none, wb_alu, 1'b1);
    else if (hit(inst_addi, inst_addi_mask))
      cs(br_none, imm_i, 1'b1, op2_imm, 1'b0, alu_add, mem_none, wb_alu, 1'b1);
    else if (hit(inst_andi, inst_andi_mask))
      cs(br_none, imm_i, 1'b1, op2_imm, 1'b0, alu_and, mem_none, wb_alu, 1'b1);
    else if (hit(inst_ori, inst_ori_mask))
      cs(br_none, imm_i, 1'b1, op2_imm, 1'b0, alu_or,  mem_none, wb_alu, 1'b1);
    else if (hit(inst_xori, inst_xori_mask))
      cs(br_none, imm_i, 1'b1, op2_imm, 1'b0, alu_xor, mem_none, wb_alu, 1'b1);
    // Load address is rs1 + imm
    else if (hit(inst_lw, inst_lw_mask))
      cs(br_none, imm_i, 1'b1, op2_imm, 1'b0, alu_add, mem_load, wb_mem, 1'b1);
    // Comparison happens in the datapath, ALU code is unused
    else if (hit(inst_bne, inst_bne_mask))
      cs(br_bne,  imm_b, 1'b1, op2_rf,  1'b1, alu_add, mem_none, wb_alu, 1'b0);
    // Unknown word: harmless bubble
    else
      cs(br_none, imm_i, 1'b0, op2_rf,  1'b0, alu_add, mem_none, wb_alu, 1'b0);
  end

  // Field extraction
  assign dec.rs1      = inst_d[rs1_lsb +: reg_addr_w];
  assign dec.rs2      = inst_d[rs2_lsb +: reg_addr_w];
  assign dec.rf_waddr = inst_d[rd_lsb +: reg_addr_w];

  assign dec.rs1_en   = rs1_en;
  assign dec.rs2_en   = rs2_en;
  assign dec.rf_wen   = rf_wen;
  assign dec.alu_fn   = alu_fn;
  assign dec.mem_type = mem_type;
  assign dec.wb_sel   = wb_sel;
  assign dec.br_type  = br_type;

endmodule

//--- logic/back_stage_tracker.sv
// Execute, memory and writeback control registers and valid bits
// Branch resolution, data-memory handshake and RAW hazard comparison
`timescale 1ns/1ns

module back_stage_tracker import isa_pkg::*, ctrl_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  decode_if.reader  dec,
  stall_if.tracker  st,
  input  logic      br_cond_eq_x,
  input  logic      dmem_req_rdy,
  input  logic      dmem_resp_val,
  output logic      dmem_req_val,
  output logic      dmem_resp_rdy,
  output logic      reg_en_x,
  output logic      reg_en_m,
  output logic      reg_en_w,
  output alu_fn_t   alu_fn_x,
  output wb_sel_t   wb_result_sel_m,
  output reg_addr_t rf_waddr_w,
  output logic      rf_wen_w,
  output logic      commit_inst
);

  logic      val_x;
  logic      val_m;
  logic      val_w;
  logic      stall_x;
  logic      stall_m;
  logic      next_val_x;
  logic      next_val_m;

  // Payload per stage
  logic      rf_wen_x;
  reg_addr_t rf_waddr_x;
  mem_type_t mem_type_x;
  wb_sel_t   wb_sel_x;
  br_type_t  br_type_x;
  logic      rf_wen_m;
  reg_addr_t rf_waddr_m;
  mem_type_t mem_type_m;
  logic      rf_wen_pend_w;

  // ------------------------------------------------------------------------
  // Execute
  // ------------------------------------------------------------------------

  // Writeback never stalls, so only X and M stall origins matter
  assign stall_x  = val_x && (st.ostall_x || st.ostall_m);
  assign reg_en_x = !stall_x;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
    end else if (reg_en_x) begin
      val_x <= st.next_val_d;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_x) begin
      rf_wen_x   <= dec.rf_wen;
      rf_waddr_x <= dec.rf_waddr;
      alu_fn_x   <= dec.alu_fn;
      mem_type_x <= dec.mem_type;
      wb_sel_x   <= dec.wb_sel;
      br_type_x  <= dec.br_type;
    end
  end

  // Taken bne redirects fetch
  assign st.pc_redirect_x = val_x && (br_type_x == br_bne) && !br_cond_eq_x;

  // Squash once, not again on every stalled cycle
  assign st.osquash_x = val_x && !stall_x && st.pc_redirect_x;

  // Load waits for the request port
  assign st.ostall_x  = val_x && (mem_type_x != mem_none) && !dmem_req_rdy;
  assign dmem_req_val = val_x && !stall_x && (mem_type_x != mem_none);

  assign next_val_x = val_x && !stall_x;

  // ------------------------------------------------------------------------
  // Memory
  // ------------------------------------------------------------------------

  assign stall_m  = val_m && st.ostall_m;
  assign reg_en_m = !stall_m;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_m <= 1'b0;
    end else if (reg_en_m) begin
      val_m <= next_val_x;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_m) begin
      rf_wen_m        <= rf_wen_x;
      rf_waddr_m      <= rf_waddr_x;
      mem_type_m      <= mem_type_x;
      wb_result_sel_m <= wb_sel_x;
    end
  end

  // Load waits for its response
  assign st.ostall_m   = val_m && (mem_type_m != mem_none) && !dmem_resp_val;
  assign dmem_resp_rdy = val_m && !stall_m && (mem_type_m != mem_none);

  assign next_val_m = val_m && !stall_m;

  // ------------------------------------------------------------------------
  // Writeback
  // ------------------------------------------------------------------------

  assign reg_en_w = 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (reg_en_w) begin
      val_w <= next_val_m;
    end
  end

  always_ff @(posedge clk) begin
    if (reg_en_w) begin
      rf_wen_pend_w <= rf_wen_m;
      rf_waddr_w    <= rf_waddr_m;
    end
  end

  assign rf_wen_w    = val_w && rf_wen_pend_w;
  assign commit_inst = val_w;

  // ------------------------------------------------------------------------
  // RAW detection, decode sources against pending destinations
  // ------------------------------------------------------------------------

  function automatic logic dest_hit(
    input logic      val,
    input logic      wen,
    input reg_addr_t waddr,
    input reg_addr_t src
  );
    return val && wen && (waddr == src) && (waddr != zero_reg);
  endfunction

  assign st.hazard_d[0] = dest_hit(val_x, rf_wen_x, rf_waddr_x, dec.rs1)
                       || dest_hit(val_m, rf_wen_m, rf_waddr_m, dec.rs1)
                       || dest_hit(val_w, rf_wen_pend_w, rf_waddr_w, dec.rs1);
  assign st.hazard_d[1] = dest_hit(val_x, rf_wen_x, rf_waddr_x, dec.rs2)
                       || dest_hit(val_m, rf_wen_m, rf_waddr_m, dec.rs2)
                       || dest_hit(val_w, rf_wen_pend_w, rf_waddr_w, dec.rs2);

endmodule

//--- logic/front_stage_ctrl.sv
// Fetch and decode valid bits, stall/squash combining
// Fetch handshake and next-PC select
`timescale 1ns/1ns

module front_stage_ctrl import ctrl_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  decode_if.reader dec,
  stall_if.front   st,
  input  logic     imem_resp_val,
  output logic     imem_req_val,
  output logic     imem_resp_rdy,
  output logic     imem_resp_drop,
  output logic     reg_en_f,
  output logic     reg_en_d,
  output pc_sel_t  pc_sel_f
);

  logic val_f;
  logic val_d;
  logic ostall_f;
  logic ostall_d;
  logic stall_f;
  logic stall_d;
  logic squash_f;
  logic squash_d;
  logic next_val_f;

  // ------------------------------------------------------------------------
  // Fetch
  // ------------------------------------------------------------------------

  // A squash overrides a stall so the wrong-path word is dropped
  assign reg_en_f = !stall_f || squash_f;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (reg_en_f) begin
      val_f <= 1'b1;
    end
  end

  assign pc_sel_f = st.pc_redirect_x ? pc_branch : pc_plus4;

  // Instruction response not back yet
  assign ostall_f = val_f && !imem_resp_val;

  assign stall_f  = val_f && (ostall_f || ostall_d || st.ostall_x || st.ostall_m);
  assign squash_f = val_f && st.osquash_x;

  // Requests go out ahead of F, never while in reset
  assign imem_req_val   = reg_en_f && !reset;
  assign imem_resp_rdy  = reg_en_f;
  assign imem_resp_drop = squash_f;

  assign next_val_f = val_f && !stall_f && !squash_f;

  // ------------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------------

  assign reg_en_d = !stall_d || squash_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (reg_en_d) begin
      val_d <= next_val_f;
    end
  end

  // Only sources the instruction really reads can stall it
  assign ostall_d = val_d && ((dec.rs1_en && st.hazard_d[0])
                           || (dec.rs2_en && st.hazard_d[1]));

  assign stall_d  = val_d && (ostall_d || st.ostall_x || st.ostall_m);
  assign squash_d = val_d && st.osquash_x;

  assign st.next_val_d = val_d && !stall_d && !squash_d;

endmodule

//--- logic/proc_ctrl.sv
// Control unit top for the five-stage pipeline
// Decoder, front-stage control and back-stage tracker on plain ports
`timescale 1ns/1ns

module proc_ctrl import isa_pkg::*, ctrl_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // Instruction memory
  output logic      imem_req_val,
  input  logic      imem_resp_val,
  output logic      imem_resp_rdy,
  output logic      imem_resp_drop,

  // Data memory
  output logic      dmem_req_val,
  input  logic      dmem_req_rdy,
  input  logic      dmem_resp_val,
  output logic      dmem_resp_rdy,

  // Controls to the datapath
  output logic      reg_en_f,
  output pc_sel_t   pc_sel_f,
  output logic      reg_en_d,
  output op2_sel_t  op2_sel_d,
  output imm_type_t imm_type_d,
  output logic      reg_en_x,
  output alu_fn_t   alu_fn_x,
  output logic      reg_en_m,
  output wb_sel_t   wb_result_sel_m,
  output logic      reg_en_w,
  output reg_addr_t rf_waddr_w,
  output logic      rf_wen_w,

  // Status from the datapath
  input  inst_t     inst_d,
  input  logic      br_cond_eq_x,

  output logic      commit_inst
);

  decode_if dec_bus ();
  stall_if  stall_bus ();

  instr_decoder decoder0 (
    .inst_d     (inst_d),
    .op2_sel_d  (op2_sel_d),
    .imm_type_d (imm_type_d),
    .dec        (dec_bus.decoder)
  );

  front_stage_ctrl front0 (
    .clk            (clk),
    .reset          (reset),
    .dec            (dec_bus.reader),
    .st             (stall_bus.front),
    .imem_resp_val  (imem_resp_val),
    .imem_req_val   (imem_req_val),
    .imem_resp_rdy  (imem_resp_rdy),
    .imem_resp_drop (imem_resp_drop),
    .reg_en_f       (reg_en_f),
    .reg_en_d       (reg_en_d),
    .pc_sel_f       (pc_sel_f)
  );

  back_stage_tracker tracker0 (
    .clk             (clk),
    .reset           (reset),
    .dec             (dec_bus.reader),
    .st              (stall_bus.tracker),
    .br_cond_eq_x    (br_cond_eq_x),
    .dmem_req_rdy    (dmem_req_rdy),
    .dmem_resp_val   (dmem_resp_val),
    .dmem_req_val    (dmem_req_val),
    .dmem_resp_rdy   (dmem_resp_rdy),
    .reg_en_x        (reg_en_x),
    .reg_en_m        (reg_en_m),
    .reg_en_w        (reg_en_w),
    .alu_fn_x        (alu_fn_x),
    .wb_result_sel_m (wb_result_sel_m),
    .rf_waddr_w      (rf_waddr_w),
    .rf_wen_w        (rf_wen_w),
    .commit_inst     (commit_inst)
  );

endmodule

//--- tests/proc_ctrl_tb.sv
// Testbench for the pipeline control unit
// Program table, decode register and stage models, data memory model, commit checker
`timescale 1ns/1ns

module proc_ctrl_tb import isa_pkg::*, ctrl_pkg::*;;

  localparam int max_rows = 32;
  localparam int timeout_cycles = 2000;

  logic      clk;
  logic      reset = 1'b1;
  inst_t     inst_d = inst_nop;
  logic      br_cond_eq_x = 1'b1;
  logic      imem_resp_val = 1'b1;
  logic      dmem_req_rdy = 1'b0;
  logic      dmem_resp_val = 1'b0;
  logic      imem_req_val, imem_resp_rdy, imem_resp_drop;
  logic      dmem_req_val, dmem_resp_rdy;
  logic      reg_en_f, reg_en_d, reg_en_x, reg_en_m, reg_en_w;
  pc_sel_t   pc_sel_f;
  op2_sel_t  op2_sel_d;
  imm_type_t imm_type_d;
  alu_fn_t   alu_fn_x;
  wb_sel_t   wb_result_sel_m;
  reg_addr_t rf_waddr_w;
  logic      rf_wen_w, commit_inst;

  // Program table with one entry per row
  inst_t     prog_inst [max_rows];
  reg_addr_t prog_rd [max_rows];
  logic      prog_wen [max_rows];
  alu_fn_t   prog_alu [max_rows];
  op2_sel_t  prog_op2 [max_rows];
  imm_type_t prog_imm [max_rows];
  logic      prog_load [max_rows];
  logic      prog_taken [max_rows];
  logic      prog_commit [max_rows];
  int        prog_gap [max_rows];
  int        n = 0;

  // Row held by each stage
  // -1 is a bubble and n is a padding nop
  int        d_row = -1;
  int        x_row = -1;
  int        m_row = -1;
  int        w_row = -1;
  int        fetch_idx = 0;
  logic      f_valid = 1'b0;
  logic      s_en_f, s_en_d, s_en_x, s_en_m, s_drop;

  int        exp_q[$];
  int        cycle = 0;
  int        last_commit = 0;
  int        resp_count = 0;
  int        loads_done = 0;
  int        drop_count = 0;
  logic [31:0] rnd = 32'd75;

  proc_ctrl dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else report_fail($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Encoders for the R, I and B formats
  function automatic inst_t enc_r(input int f7, input int f3, input int rd, input int rs1,
                                  input int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
  endfunction

  function automatic inst_t enc_i(input int imm, input int f3, input int rd, input int rs1,
                                  input int op);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
  endfunction

  function automatic inst_t enc_bne(input int rs1, input int rs2);
    return {7'd0, 5'(rs2), 5'(rs1), 3'b001, 5'd0, 7'h63};
  endfunction

  task automatic add_row(input inst_t inst, input int rd, input logic wen, input alu_fn_t alu,
                         input op2_sel_t op2, input imm_type_t imm, input logic load,
                         input logic taken, input logic commit, input int gap);
    prog_inst[n]   = inst;
    prog_rd[n]     = reg_addr_t'(rd);
    prog_wen[n]    = wen;
    prog_alu[n]    = alu;
    prog_op2[n]    = op2;
    prog_imm[n]    = imm;
    prog_load[n]   = load;
    prog_taken[n]  = taken;
    prog_commit[n] = commit;
    prog_gap[n]    = gap;
    n = n + 1;
  endtask

  // --------------------------------------------------------------------------
  // Stage models and stimulus advanced from the enables sampled last cycle
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    int nd;
    int nx;
    int nm;
    int nw;
    nd = d_row;
    nx = x_row;
    nm = m_row;
    rnd = xorshift(rnd);
    dmem_req_rdy  <= rnd[3];
    dmem_resp_val <= rnd[9];
    if (reset) begin
      nd = -1;
      nx = -1;
      nm = -1;
      nw = -1;
      fetch_idx = 0;
      f_valid = 1'b0;
    end else begin
      cycle = cycle + 1;
      nw = (m_row != -1 && s_en_m) ? m_row : -1;
      if (s_en_m)
        nm = (x_row != -1 && s_en_x) ? x_row : -1;
      if (s_en_x)
        nx = (d_row != -1 && s_en_d && !s_drop) ? d_row : -1;
      if (s_en_d) begin
        // Squash drops decode and the fetch row behind it
        if (s_drop) begin
          nd = -1;
          fetch_idx = (x_row + 3 > n) ? n : x_row + 3;
        end else if (f_valid && s_en_f) begin
          nd = fetch_idx;
          if (fetch_idx < n)
            fetch_idx = fetch_idx + 1;
        end else begin
          nd = -1;
        end
      end
      f_valid = 1'b1;
    end
    d_row = nd;
    x_row = nx;
    m_row = nm;
    w_row = nw;
    inst_d <= (nd >= 0 && nd < n) ? prog_inst[nd] : inst_nop;
    br_cond_eq_x <= !(nx >= 0 && nx < n && prog_taken[nx]);
  end

  // --------------------------------------------------------------------------
  // Checks at the falling edge where outputs are settled
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    logic x_taken;
    logic m_load_wait;
    s_en_f = reg_en_f;
    s_en_d = reg_en_d;
    s_en_x = reg_en_x;
    s_en_m = reg_en_m;
    s_drop = imem_resp_drop;
    x_taken = x_row >= 0 && x_row < n && prog_taken[x_row];
    // A load waiting for its response holds execute behind it
    m_load_wait = m_row >= 0 && m_row < n && prog_load[m_row] && !dmem_resp_val;
    // Writeback never stalls
    expect_eq("reg_en_w", 32'(reg_en_w), 32'd1);
    if (reset)
      expect_eq("imem_req_val", 32'(imem_req_val), 32'd0);
    else
      expect_eq("imem_req_val", 32'(imem_req_val), 32'(reg_en_f));
    expect_eq("imem_resp_rdy", 32'(imem_resp_rdy), 32'(reg_en_f));
    if (d_row >= 0 && d_row < n) begin
      expect_eq("op2_sel_d", 32'(op2_sel_d), 32'(prog_op2[d_row]));
      expect_eq("imm_type_d", 32'(imm_type_d), 32'(prog_imm[d_row]));
    end
    if (x_row >= 0 && x_row < n)
      expect_eq("alu_fn_x", 32'(alu_fn_x), 32'(prog_alu[x_row]));
    if (m_row >= 0 && m_row < n)
      expect_eq("wb_result_sel_m", 32'(wb_result_sel_m),
                prog_load[m_row] ? 32'(wb_mem) : 32'(wb_alu));
    assert (!dmem_req_val || (x_row >= 0 && x_row < n && prog_load[x_row]))
    else report_fail("Data memory request raised without a load in execute");
    assert (!dmem_resp_rdy || (m_row >= 0 && m_row < n && prog_load[m_row]))
    else report_fail("Data memory response ready without a load in memory");
    if (dmem_resp_val && dmem_resp_rdy)
      resp_count = resp_count + 1;
    // Taken bne in execute selects the branch target
    expect_eq("pc_sel_f", 32'(pc_sel_f), x_taken ? 32'(pc_branch) : 32'(pc_plus4));
    // Squash exactly when a taken bne leaves execute
    expect_eq("imem_resp_drop", 32'(imem_resp_drop), 32'(x_taken && !m_load_wait));
    if (imem_resp_drop)
      drop_count = drop_count + 1;
    expect_eq("commit_inst", 32'(commit_inst), 32'(w_row != -1));
    if (!commit_inst) begin
      expect_eq("rf_wen_w", 32'(rf_wen_w), 32'd0);
    end else if (exp_q.size() == 0) begin
      // Padding nops past the end of the program
      expect_eq("rf_wen_w", 32'(rf_wen_w), 32'd0);
    end else begin
      expect_eq("commit row", 32'(w_row), 32'(exp_q[0]));
      expect_eq("rf_waddr_w", 32'(rf_waddr_w), 32'(prog_rd[w_row]));
      expect_eq("rf_wen_w", 32'(rf_wen_w), 32'(prog_wen[w_row]));
      if (prog_gap[w_row] != 0)
        expect_eq("commit spacing", 32'(cycle - last_commit), 32'(prog_gap[w_row]));
      if (prog_load[w_row]) begin
        assert (resp_count > loads_done)
        else report_fail("Load committed before its data memory response");
        loads_done = loads_done + 1;
      end
      last_commit = cycle;
      void'(exp_q.pop_front());
    end
  end

  // --------------------------------------------------------------------------
  // Program and run control
  // --------------------------------------------------------------------------
  initial begin
    int waited;
    int exp_drops;
    //      word                        rd wen   alu      op2      imm    ld    tk    cm  gap
    add_row(enc_i(5, 0, 1, 0, 'h13),     1, 1'b1, alu_add, op2_imm, imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_i(3, 4, 2, 0, 'h13),     2, 1'b1, alu_xor, op2_imm, imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_i(1, 6, 3, 0, 'h13),     3, 1'b1, alu_or,  op2_imm, imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_i(7, 7, 4, 0, 'h13),     4, 1'b1, alu_and, op2_imm, imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_r(0, 0, 5, 10, 11),      5, 1'b1, alu_add, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_r('h20, 0, 6, 12, 13),   6, 1'b1, alu_sub, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_r(0, 7, 7, 14, 15),      7, 1'b1, alu_and, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_r(0, 6, 8, 16, 17),      8, 1'b1, alu_or,  op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_r(0, 4, 9, 18, 19),      9, 1'b1, alu_xor, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    // RAW chain through rs1 then rs2 and then x0 which never waits
    add_row(enc_r(0, 0, 20, 21, 22),    20, 1'b1, alu_add, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_r('h20, 0, 23, 20, 24), 23, 1'b1, alu_sub, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 4);
    add_row(enc_r(0, 4, 25, 26, 23),    25, 1'b1, alu_xor, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 4);
    add_row(enc_r(0, 0, 0, 1, 2),        0, 1'b1, alu_add, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_r(0, 7, 26, 0, 0),      26, 1'b1, alu_and, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 1);
    add_row(inst_nop,                    0, 1'b0, alu_add, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    // Loads under random memory readiness
    add_row(enc_i(0, 2, 10, 1, 'h03),   10, 1'b1, alu_add, op2_imm, imm_i, 1'b1, 1'b0, 1'b1, 0);
    add_row(enc_i(4, 2, 11, 10, 'h03),  11, 1'b1, alu_add, op2_imm, imm_i, 1'b1, 1'b0, 1'b1, 0);
    add_row(enc_r(0, 0, 12, 10, 11),    12, 1'b1, alu_add, op2_rf,  imm_i, 1'b0, 1'b0, 1'b1, 0);
    // Taken bne skips two rows and a not-taken bne skips none
    add_row(enc_bne(1, 2),               0, 1'b0, alu_add, op2_rf,  imm_b, 1'b0, 1'b1, 1'b1, 0);
    add_row(enc_i(1, 0, 15, 0, 'h13),   15, 1'b1, alu_add, op2_imm, imm_i, 1'b0, 1'b0, 1'b0, 0);
    add_row(enc_i(2, 0, 16, 0, 'h13),   16, 1'b1, alu_add, op2_imm, imm_i, 1'b0, 1'b0, 1'b0, 0);
    add_row(enc_i(2, 6, 17, 1, 'h13),   17, 1'b1, alu_or,  op2_imm, imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_bne(3, 4),               0, 1'b0, alu_add, op2_rf,  imm_b, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_i(3, 6, 18, 0, 'h13),   18, 1'b1, alu_or,  op2_imm, imm_i, 1'b0, 1'b0, 1'b1, 0);
    add_row(enc_i(8, 2, 20, 1, 'h03),   20, 1'b1, alu_add, op2_imm, imm_i, 1'b1, 1'b0, 1'b1, 0);
    add_row(enc_bne(20, 0),              0, 1'b0, alu_add, op2_rf,  imm_b, 1'b0, 1'b1, 1'b1, 0);
    add_row(enc_i(4, 4, 21, 0, 'h13),   21, 1'b1, alu_xor, op2_imm, imm_i, 1'b0, 1'b0, 1'b0, 0);
    add_row(enc_i(5, 7, 22, 0, 'h13),   22, 1'b1, alu_and, op2_imm, imm_i, 1'b0, 1'b0, 1'b0, 0);
    add_row(enc_i(9, 0, 24, 0, 'h13),   24, 1'b1, alu_add, op2_imm, imm_i, 1'b0, 1'b0, 1'b1, 0);

    exp_drops = 0;
    for (int i = 0; i < n; i++) begin
      if (prog_commit[i])
        exp_q.push_back(i);
      if (prog_taken[i])
        exp_drops = exp_drops + 1;
    end

    repeat (5) @(posedge clk);
    reset <= 1'b0;

    waited = 0;
    while (exp_q.size() != 0 && waited < timeout_cycles) begin
      @(posedge clk);
      waited = waited + 1;
    end
    if (exp_q.size() != 0)
      report_fail("Timed out waiting for the program to commit");
    @(posedge clk);

    if (drop_count != exp_drops) begin
      report_fail($sformatf("[FAIL] squash count got %h expected %h", drop_count, exp_drops));
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- filelist.f
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/decode_if.sv
logic/stall_if.sv
logic/instr_decoder.sv
logic/back_stage_tracker.sv
logic/front_stage_ctrl.sv
logic/proc_ctrl.sv
tests/proc_ctrl_tb.sv

//--- Makefile
# Verilator simulation of the pipeline control unit

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, check the log for a pass"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f filelist.f --top-module proc_ctrl_tb -Mdir obj_dir
	./obj_dir/Vproc_ctrl_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
